//--- design/alu.sv
`timescale 1ns/1ps

module alu (
    input  riscv_pkg::word_t   a,
    input  riscv_pkg::word_t   b,
    input  riscv_pkg::alu_op_e op,
    output riscv_pkg::word_t   result,
    output logic               zero
);
    import riscv_pkg::*;

    logic [4:0] shamt;
    logic       less;

    assign shamt = b[4:0];                  // shifts take the low five bits.
    assign less  = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'b0, less};
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            ALU_SRA: result = word_t'($signed(a) >>> shamt);
            default: result = '0;
        endcase
    end

    // branches compare through this flag after a subtraction.
    assign zero = (result == '0);

endmodule

//--- design/decode_ctrl_if.sv
`timescale 1ns/1ps

// decoded control of the instruction currently on the fetch port.
interface decode_ctrl_if;
    import riscv_pkg::*;

    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    logic      alu_src_imm;   // second operand is imm instead of rs2.
    wb_sel_e   wb_sel;
    logic      reg_write;
    logic      mem_write;
    logic      branch;
    logic      branch_on_ne;  // bne when high, beq when low.
    logic      jump;
    word_t     imm;

    modport producer (
        output alu_op, src1_sel, alu_src_imm, wb_sel, reg_write,
        output mem_write, branch, branch_on_ne, jump, imm
    );

    modport consumer (
        input alu_op, src1_sel, alu_src_imm, wb_sel, reg_write,
        input mem_write, branch, branch_on_ne, jump, imm
    );

endinterface

//--- design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                CLK,
    input  logic                RESET_N,
    decode_ctrl_if.consumer     ctrl,
    input  riscv_pkg::word_t    rs1_data,
    input  riscv_pkg::word_t    rs2_data,
    input  riscv_pkg::word_t    mem_rdata,
    output riscv_pkg::addr_t    pc,
    output riscv_pkg::addr_t    mem_addr,
    output riscv_pkg::word_t    store_data,
    output logic                mem_write,
    output riscv_pkg::word_t    wb_data,
    output logic                reg_write
);
    import riscv_pkg::*;

    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    logic  alu_zero;
    addr_t pc_plus4;
    addr_t branch_target;
    logic  take_target;
    addr_t next_pc;

    // ========================================================================
    // Operand selection and ALU.
    // ========================================================================

    always_comb begin
        case (ctrl.src1_sel)
            SRC1_PC:   alu_a = pc;      // auipc.
            SRC1_ZERO: alu_a = '0;      // lui.
            default:   alu_a = rs1_data;
        endcase
    end

    assign alu_b = ctrl.alu_src_imm ? ctrl.imm : rs2_data;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // the ALU result doubles as the data address for lw and sw.
    assign mem_addr   = alu_result;
    assign store_data = rs2_data;
    assign mem_write  = ctrl.mem_write;

    // ========================================================================
    // Write-back and next program counter.
    // ========================================================================

    assign pc_plus4      = pc + PC_STEP;
    assign branch_target = pc + ctrl.imm;

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = mem_rdata;
            WB_PC4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    assign reg_write = ctrl.reg_write;

    // beq is taken on equal operands, bne on unequal ones, jal always.
    assign take_target = ctrl.jump ||
                         (ctrl.branch && (ctrl.branch_on_ne ? !alu_zero : alu_zero));
    assign next_pc     = take_target ? branch_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;   // one instruction retires every cycle.
        end
    end

endmodule

//--- design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  riscv_pkg::word_t instr,
    decode_ctrl_if.producer  ctrl
);
    import riscv_pkg::*;

    opcode_e opcode;
    funct3_t funct3;
    logic    bit30;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_j;
    word_t   imm_u;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign bit30  = instr[30];

    // ========================================================================
    // Immediate formats, all sign extended from bit 31.
    // ========================================================================

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // ALU control for register and immediate arithmetic.
    // bit 30 picks sub only in the register form, since there is no subi.
    function automatic alu_op_e arith_op(input funct3_t f3, input logic alt,
                                         input logic reg_form);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = (alt && reg_form) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    // ========================================================================
    // Main control.
    // ========================================================================

    always_comb begin
        // defaults describe a no-operation.
        ctrl.alu_op       = ALU_ADD;
        ctrl.src1_sel     = SRC1_RS1;
        ctrl.alu_src_imm  = 1'b0;
        ctrl.wb_sel       = WB_ALU;
        ctrl.reg_write    = 1'b0;
        ctrl.mem_write    = 1'b0;
        ctrl.branch       = 1'b0;
        ctrl.branch_on_ne = 1'b0;
        ctrl.jump         = 1'b0;
        ctrl.imm          = '0;

        case (opcode)
            OPC_OP: begin
                ctrl.alu_op    = arith_op(funct3, bit30, 1'b1);
                ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op      = arith_op(funct3, bit30, 1'b0);
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm         = imm_i;  // shifts only use its low five bits.
                ctrl.reg_write   = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm         = imm_i;
                ctrl.wb_sel      = WB_MEM;
                ctrl.reg_write   = 1'b1;
            end
            OPC_STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm         = imm_s;
                ctrl.mem_write   = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.alu_op       = ALU_SUB;  // compare through the zero flag.
                ctrl.imm          = imm_b;
                ctrl.branch       = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                ctrl.branch_on_ne = (funct3 == F3_BNE);
            end
            OPC_JAL: begin
                ctrl.imm       = imm_j;
                ctrl.jump      = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                ctrl.reg_write = 1'b1;
            end
            OPC_LUI: begin
                ctrl.src1_sel    = SRC1_ZERO;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm         = imm_u;
                ctrl.reg_write   = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.src1_sel    = SRC1_PC;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm         = imm_u;
                ctrl.reg_write   = 1'b1;
            end
            default: begin
                // unknown opcodes keep the no-operation defaults.
            end
        endcase
    end

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                CLK,
    input  logic                RESET_N,
    input  riscv_pkg::reg_idx_t rs1_idx,
    input  riscv_pkg::reg_idx_t rs2_idx,
    input  riscv_pkg::reg_idx_t rd_idx,
    input  riscv_pkg::word_t    wb_data,
    input  logic                reg_write,
    output riscv_pkg::word_t    rs1_data,
    output riscv_pkg::word_t    rs2_data
);
    import riscv_pkg::*;

    word_t regs [0:31];   // entry 0 is cleared by reset and never written.

    // ========================================================================
    // Write port.
    // ========================================================================

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && (rd_idx != '0)) begin
            regs[rd_idx] <= wb_data;
        end
    end

    // reads are combinational, so a register written this cycle still shows
    // its old value until the edge.
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- design/riscv_core.sv
`timescale 1ns/1ps

module riscv_core (
    input  logic             CLK,
    input  logic             RESET_N,
    input  riscv_pkg::word_t q_rom,
    output riscv_pkg::addr_t addr_rom,
    output riscv_pkg::addr_t addr_ram,
    input  riscv_pkg::word_t q_ram,
    output riscv_pkg::word_t q_w,
    output logic             enable_w
);
    import riscv_pkg::*;

    word_t rs1_data;
    word_t rs2_data;
    word_t wb_data;
    logic  reg_write;

    decode_ctrl_if ctrl_if ();

    // ========================================================================
    // Decode and register read work on the same fetched word.
    // ========================================================================

    instr_decoder u_decoder (
        .instr (q_rom),
        .ctrl  (ctrl_if.producer)
    );

    register_file u_regfile (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .rs1_idx   (q_rom[19:15]),
        .rs2_idx   (q_rom[24:20]),
        .rd_idx    (q_rom[11:7]),
        .wb_data   (wb_data),
        .reg_write (reg_write),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    // execute drives the fetch address from its program counter.
    execute_unit u_execute (
        .CLK        (CLK),
        .RESET_N    (RESET_N),
        .ctrl       (ctrl_if.consumer),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .mem_rdata  (q_ram),
        .pc         (addr_rom),
        .mem_addr   (addr_ram),
        .store_data (q_w),
        .mem_write  (enable_w),
        .wb_data    (wb_data),
        .reg_write  (reg_write)
    );

endmodule

//--- design/riscv_pkg.sv
package riscv_pkg;

    // ========================================================================
    // Word, address and register index types.
    // ========================================================================

    typedef logic [31:0] word_t;     // register values, operands and memory data.
    typedef logic [31:0] addr_t;     // byte addresses for fetch and data access.
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    localparam addr_t PC_STEP  = 32'd4;  // one instruction word.
    localparam addr_t RESET_PC = 32'd0;

    // ========================================================================
    // Encodings for the decoder and the datapath.
    // ========================================================================

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // the first ALU operand comes from one of these.
    typedef enum logic [1:0] {
        SRC1_PC   = 2'd0,
        SRC1_ZERO = 2'd1,
        SRC1_RS1  = 2'd2
    } src1_sel_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2    // return address for jal.
    } wb_sel_e;

    // funct3 values of the supported operations.
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SR      = 3'b101;  // srl or sra, told apart by bit 30.
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;

endpackage

//--- run_sim.sh
#!/bin/sh
# Compiles the core and its testbench with Verilator and runs the simulation.
# Exits with status 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module riscv_core_tb \
    -Mdir obj_dir \
    -f rv_single_cycle.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "run_sim.sh: Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vriscv_core_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "run_sim.sh: simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -q "^PASS: all tests$"; then
    echo "run_sim.sh: simulation passed"
    exit 0
else
    echo "run_sim.sh: pass message not found in simulation output"
    exit 1
fi

//--- rv_single_cycle.f
design/riscv_pkg.sv
design/decode_ctrl_if.sv
design/alu.sv
design/instr_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/riscv_core.sv
verification/riscv_core_properties.sv
verification/riscv_core_tb.sv

//--- verification/riscv_core_properties.sv
`timescale 1ns/1ps

module riscv_core_properties (
    input logic             CLK,
    input logic             RESET_N,
    input riscv_pkg::addr_t addr_rom,
    input riscv_pkg::addr_t addr_ram,
    input riscv_pkg::word_t q_w,
    input logic             enable_w,
    input riscv_pkg::addr_t exp_pc,
    input logic             exp_is_store,
    input riscv_pkg::addr_t exp_store_addr,
    input riscv_pkg::word_t exp_store_data
);
    import riscv_pkg::*;

    // ========================================================================
    // Fetch port against the shadow program counter.
    // ========================================================================

    reset_fetch: assert property (@(posedge CLK) !RESET_N |-> addr_rom == RESET_PC)
        else $error("[ERROR] reset_fetch expected %h actual %h", RESET_PC, addr_rom);

    // first cycle out of reset still fetches from the reset address.
    first_fetch: assert property (@(posedge CLK) $rose(RESET_N) |-> addr_rom == RESET_PC)
        else $error("[ERROR] first_fetch expected %h actual %h", RESET_PC, addr_rom);

    fetch_follows_model: assert property (@(posedge CLK) disable iff (!RESET_N)
        addr_rom == exp_pc)
        else $error("[ERROR] fetch_follows_model expected %h actual %h", exp_pc, addr_rom);

    // ========================================================================
    // Store port.
    // ========================================================================

    store_only_on_sw: assert property (@(posedge CLK) disable iff (!RESET_N)
        enable_w == exp_is_store)
        else $error("[ERROR] store_only_on_sw expected %b actual %b",
                    exp_is_store, enable_w);

    store_address: assert property (@(posedge CLK) disable iff (!RESET_N)
        exp_is_store |-> addr_ram == exp_store_addr)
        else $error("[ERROR] store_address expected %h actual %h", exp_store_addr, addr_ram);

    store_value: assert property (@(posedge CLK) disable iff (!RESET_N)
        exp_is_store |-> q_w == exp_store_data)
        else $error("[ERROR] store_value expected %h actual %h", exp_store_data, q_w);

endmodule

//--- verification/riscv_core_tb.sv
`timescale 1ns/1ps

module riscv_core_tb;
    import riscv_pkg::*;

    localparam int ROM_WORDS = 128;
    localparam int RAM_WORDS = 64;

    logic       CLK = 1'b0;
    logic       RESET_N;
    word_t      q_rom;
    addr_t      addr_rom;
    addr_t      addr_ram;
    word_t      q_ram;
    word_t      q_w;
    logic       enable_w;

    word_t      rom [0:ROM_WORDS-1];
    word_t      ram [0:RAM_WORDS-1];
    word_t      rnd_words [0:2];       // preloaded at data addresses 0, 4 and 8.
    logic [6:0] n_instr;
    addr_t      halt_pc;
    int         cycle_limit = 1000;
    int         cycle_count = 0;

    // shadow architectural state.
    addr_t      exp_pc;
    word_t      exp_regs [0:31];
    word_t      cur_instr;
    logic       exp_is_store;
    addr_t      exp_store_addr;
    word_t      exp_store_data;

    always #20 CLK = ~CLK;

    riscv_core dut0 (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .q_rom    (q_rom),
        .addr_rom (addr_rom),
        .addr_ram (addr_ram),
        .q_ram    (q_ram),
        .q_w      (q_w),
        .enable_w (enable_w)
    );

    bind riscv_core riscv_core_properties props0 (
        .CLK            (CLK),
        .RESET_N        (RESET_N),
        .addr_rom       (addr_rom),
        .addr_ram       (addr_ram),
        .q_w            (q_w),
        .enable_w       (enable_w),
        .exp_pc         (riscv_core_tb.exp_pc),
        .exp_is_store   (riscv_core_tb.exp_is_store),
        .exp_store_addr (riscv_core_tb.exp_store_addr),
        .exp_store_data (riscv_core_tb.exp_store_data)
    );

    // ========================================================================
    // Memory models, read combinationally.
    // ========================================================================

    assign q_rom = rom[addr_rom[8:2]];
    assign q_ram = ram[addr_ram[7:2]];

    always @(posedge CLK) begin
        if (enable_w) begin
            ram[addr_ram[7:2]] <= q_w;
        end
    end

    // ========================================================================
    // Instruction encoders and immediate fields, following the ISA formats.
    // ========================================================================

    function automatic word_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t imm_op(input logic [2:0] f3, input reg_idx_t rd,
                                     input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t load_word(input reg_idx_t rd, input reg_idx_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, OPC_LOAD};
    endfunction

    function automatic word_t store_word(input reg_idx_t rs2, input reg_idx_t rs1,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t branch_op(input logic [2:0] f3, input reg_idx_t rs1,
                                        input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t jump_link(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t upper_imm(input opcode_e opc, input reg_idx_t rd,
                                        input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t i_imm(input word_t w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic word_t s_imm(input word_t w);
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic word_t b_imm(input word_t w);
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic word_t j_imm(input word_t w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    // reference results of the arithmetic and logic instructions.
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input word_t w);
        rom[n_instr] = w;
        n_instr = n_instr + 7'd1;
    endtask

    task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = 32'h0000_0013;                       // addi x0, x0, 0.
        end
        n_instr = '0;
        emit(imm_op(3'b000, 5'd1, 5'd0, 12'd100));
        emit(imm_op(3'b000, 5'd2, 5'd0, 12'hFF9));        // x2 = -7.
        emit(imm_op(3'b000, 5'd20, 5'd0, 12'd128));       // result area base.
        emit(imm_op(3'b000, 5'd9, 5'd0, 12'd3));
        emit(reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(reg_op(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
        emit(reg_op(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
        emit(reg_op(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
        emit(reg_op(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
        emit(reg_op(7'h00, 3'b010, 5'd8, 5'd2, 5'd1));
        emit(reg_op(7'h00, 3'b001, 5'd10, 5'd1, 5'd9));
        emit(reg_op(7'h00, 3'b101, 5'd11, 5'd2, 5'd9));
        emit(reg_op(7'h20, 3'b101, 5'd12, 5'd2, 5'd9));
        for (int r = 3; r <= 12; r++) begin
            if (r != 9) begin
                emit(store_word(reg_idx_t'(r), 5'd20, 12'((r - 3) * 4)));
            end
        end
        emit(imm_op(3'b100, 5'd21, 5'd1, 12'h055));
        emit(imm_op(3'b110, 5'd22, 5'd1, 12'h030));
        emit(imm_op(3'b111, 5'd23, 5'd2, 12'h7F0));
        emit(imm_op(3'b010, 5'd24, 5'd2, 12'hFFF));
        emit(imm_op(3'b001, 5'd25, 5'd1, 12'h005));
        emit(imm_op(3'b101, 5'd26, 5'd2, 12'h004));
        emit(imm_op(3'b101, 5'd27, 5'd2, 12'h404));        // srai.
        emit(imm_op(3'b000, 5'd28, 5'd1, 12'hF38));        // addi -200.
        for (int r = 21; r <= 28; r++) begin
            emit(store_word(reg_idx_t'(r), 5'd20, 12'(40 + (r - 21) * 4)));
        end
        for (int k = 0; k < 3; k++) begin
            emit(load_word(reg_idx_t'(13 + k), 5'd0, 12'(k * 4)));
        end
        for (int k = 0; k < 3; k++) begin
            emit(store_word(reg_idx_t'(13 + k), 5'd0, 12'(64 + k * 4)));
        end
        // each branch jumps over one increment of x16 when it is taken.
        emit(branch_op(3'b000, 5'd1, 5'd1, 13'd8));
        emit(imm_op(3'b000, 5'd16, 5'd16, 12'd1));
        emit(branch_op(3'b001, 5'd1, 5'd1, 13'd8));
        emit(imm_op(3'b000, 5'd16, 5'd16, 12'd2));
        emit(branch_op(3'b000, 5'd1, 5'd2, 13'd8));
        emit(imm_op(3'b000, 5'd16, 5'd16, 12'd4));
        emit(branch_op(3'b001, 5'd1, 5'd2, 13'd8));
        emit(imm_op(3'b000, 5'd16, 5'd16, 12'd8));
        emit(jump_link(5'd17, 21'd8));
        emit(imm_op(3'b000, 5'd16, 5'd16, 12'd16));
        emit(upper_imm(OPC_LUI, 5'd18, 20'h12345));
        emit(upper_imm(OPC_AUIPC, 5'd19, 20'h00010));
        emit(imm_op(3'b000, 5'd0, 5'd0, 12'd55));
        for (int r = 16; r <= 19; r++) begin
            emit(store_word(reg_idx_t'(r), 5'd20, 12'(72 + (r - 16) * 4)));
        end
        emit(store_word(5'd0, 5'd20, 12'd88));
        halt_pc = {23'd0, n_instr, 2'b00};
        emit(jump_link(5'd0, 21'd0));                     // halt loop.
        cycle_limit = 2 * int'(n_instr) + 20;
    endtask

    task automatic fill_ram();
        for (int i = 0; i < 3; i++) begin
            rnd_words[i] = $urandom();
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            if (i < 3) begin
                ram[i] <= rnd_words[i];
            end else begin
                ram[i] <= 32'hC0DE_0000 ^ (word_t'(i * 4) * 32'h0001_0101);
            end
        end
    endtask

    // ========================================================================
    // Shadow model, one instruction per rising edge.
    // ========================================================================

    task automatic step_model();
        word_t instr;
        word_t a;
        word_t b;
        word_t val;
        addr_t ld_addr;
        addr_t next_pc;
        logic  wr;
        instr   = rom[exp_pc[8:2]];
        a       = exp_regs[instr[19:15]];
        b       = exp_regs[instr[24:20]];
        next_pc = exp_pc + PC_STEP;
        wr      = 1'b1;
        val     = '0;
        case (instr[6:0])
            OPC_OP:     val = alu_ref(instr[14:12], instr[30], a, b);
            OPC_OP_IMM: val = alu_ref(instr[14:12], (instr[14:12] == 3'b101) && instr[30],
                                      a, i_imm(instr));
            OPC_LOAD: begin
                ld_addr = a + i_imm(instr);
                val     = ram[ld_addr[7:2]];
            end
            OPC_BRANCH: begin
                wr = 1'b0;
                if ((instr[14:12] == 3'b000) ? (a == b) : (a != b)) begin
                    next_pc = exp_pc + b_imm(instr);
                end
            end
            OPC_JAL: begin
                val     = exp_pc + PC_STEP;            // return address.
                next_pc = exp_pc + j_imm(instr);
            end
            OPC_LUI:   val = {instr[31:12], 12'b0};
            OPC_AUIPC: val = exp_pc + {instr[31:12], 12'b0};
            default:   wr = 1'b0;                      // stores and no-operations.
        endcase
        if (wr && (instr[11:7] != 5'd0)) begin
            exp_regs[instr[11:7]] <= val;
        end
        exp_pc <= next_pc;
    endtask

    always @(posedge CLK) begin
        if (!RESET_N) begin
            exp_pc <= RESET_PC;
            for (int i = 0; i < 32; i++) begin
                exp_regs[i] <= '0;
            end
        end else begin
            step_model();
        end
    end

    assign cur_instr      = rom[exp_pc[8:2]];
    assign exp_is_store   = (cur_instr[6:0] == OPC_STORE);
    assign exp_store_addr = exp_regs[cur_instr[19:15]] + s_imm(cur_instr);
    assign exp_store_data = exp_regs[cur_instr[24:20]];

    // ========================================================================
    // Checks, failure handling and the run itself.
    // ========================================================================

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic report_mismatch(input string test, input word_t exp, input word_t act);
        $display("[ERROR] %s expected %h actual %h", test, exp, act);
        stop_with_failure();
    endtask

    // outputs are combinational and settle well before the falling edge.
    always @(negedge CLK) begin
        if (!RESET_N) begin
            assert (addr_rom == RESET_PC) else report_mismatch("reset_fetch", RESET_PC, addr_rom);
        end else begin
            assert (addr_rom == exp_pc) else report_mismatch("fetch_pc", exp_pc, addr_rom);
            assert (enable_w == exp_is_store)
                else report_mismatch("store_enable", word_t'(exp_is_store), word_t'(enable_w));
            if (exp_is_store) begin
                assert (addr_ram == exp_store_addr)
                    else report_mismatch("store_addr", exp_store_addr, addr_ram);
                assert (q_w == exp_store_data)
                    else report_mismatch("store_data", exp_store_data, q_w);
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the program did not reach its halt loop in %0d cycles",
                     cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        void'($urandom(90648));
        RESET_N <= 1'b0;
        load_program();
        fill_ram();
        repeat (3) @(posedge CLK);
        RESET_N <= 1'b1;
        do begin
            @(negedge CLK);
        end while (addr_rom != halt_pc);
        repeat (2) @(posedge CLK);                    // stay in the halt loop a little.
        @(negedge CLK);
        for (int k = 0; k < 3; k++) begin
            assert (ram[16 + k] == rnd_words[k])
                else report_mismatch("lw_sw_copy", rnd_words[k], ram[16 + k]);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule
